//--- hw/mips_pkg.sv
package mips_pkg;

    // program counter value after reset
    localparam logic [31:0] reset_vector = 32'hBFC0_0000;

    // instruction rom depth in words
    localparam int rom_words = 4096;

    // primary opcodes
    localparam logic [5:0] op_special = 6'd0;
    localparam logic [5:0] op_lw      = 6'd35;
    localparam logic [5:0] op_sw      = 6'd43;
    localparam logic [5:0] op_addiu   = 6'd9;

    // funct field of special opcode
    localparam logic [5:0] fn_jr    = 6'd8;
    localparam logic [5:0] fn_multu = 6'd25;
    localparam logic [5:0] fn_mfhi  = 6'd16;
    localparam logic [5:0] fn_mflo  = 6'd18;

    // one instruction word seen through its three formats
    typedef union packed {
        // register format
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        // immediate format
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        // jump format
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } instr_t;

endpackage

//--- hw/instr_rom.sv
`timescale 1ns/1ps

module instr_rom import mips_pkg::*; (
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata
);

    logic [31:0] rom [0:rom_words-1];

    // offset from the boot address, then word index
    logic [31:0] rom_offset;
    logic [$clog2(rom_words)-1:0] word_index;

    assign rom_offset = instr_address % reset_vector;
    assign word_index = rom_offset[$clog2(rom_words)+1:2];

    initial begin
        instr_t word;
        int     idx;
        int     n;

        // unused words read as sll r0, which does nothing
        for (int k = 0; k < rom_words; k++) begin
            rom[k] = 32'h0;
        end
        idx = 0;

        // lw rn, 4*(n-2)(r0) for r2 .. r16
        for (n = 2; n <= 16; n++) begin
            word          = '0;
            word.i.opcode = op_lw;
            word.i.rs     = 5'd0;
            word.i.rt     = 5'(n);
            word.i.imm    = 16'((n - 2) * 4);
            rom[idx]      = word;
            idx++;
        end

        // multu r(n-1), rn then lo into r(n-1) and hi into r(n+14)
        for (n = 3; n <= 16; n++) begin
            word         = '0;
            word.r.rs    = 5'(n - 1);
            word.r.rt    = 5'(n);
            word.r.funct = fn_multu;
            rom[idx]     = word;
            idx++;
            word         = '0;
            word.r.rd    = 5'(n - 1);
            word.r.funct = fn_mflo;
            rom[idx]     = word;
            idx++;
            word         = '0;
            word.r.rd    = 5'(n + 14);
            word.r.funct = fn_mfhi;
            rom[idx]     = word;
            idx++;
        end

        // hi word from r17 .. r30, lo word from r2 .. r15, packed pairwise at 0x400
        for (n = 17; n <= 30; n++) begin
            word          = '0;
            word.i.opcode = op_sw;
            word.i.rt     = 5'(n);
            word.i.imm    = 16'(16'h400 + (n - 17) * 8);
            rom[idx]      = word;
            idx++;
            word.i.rt     = 5'(n - 15);
            word.i.imm    = word.i.imm + 16'd4;
            rom[idx]      = word;
            idx++;
        end

        // jr r0 ends the program after its delay slot
        word         = '0;
        word.r.funct = fn_jr;
        rom[idx]     = word;
        idx++;

        // delay slot, addiu r2, r0, 0
        word          = '0;
        word.i.opcode = op_addiu;
        word.i.rt     = 5'd2;
        rom[idx]      = word;
    end

    // combinational fetch
    assign instr_readdata = rom[word_index];

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data
);

    logic [31:0] regs [0:31];

    // two asynchronous read ports
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // single write port, r0 never written so it stays zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= 32'h0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

//--- hw/hilo_unit.sv
`timescale 1ns/1ps

module hilo_unit import mips_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        mult_en,
    input  logic [31:0] op_a,
    input  logic [31:0] op_b,
    output logic [31:0] hi,
    output logic [31:0] lo
);

    // full width unsigned product
    logic [63:0] product;

    // zero extend both operands, no sign handling
    assign product = {32'h0, op_a} * {32'h0, op_b};

    // hi and lo update at the edge closing the multu cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= 32'h0;
            lo <= 32'h0;
        end else if (mult_en) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end
    end

endmodule

//--- hw/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,

    // instruction fetch
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,

    // register file
    output logic [4:0]  rs_addr,
    output logic [4:0]  rt_addr,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    output logic        wr_en,
    output logic [4:0]  wr_addr,
    output logic [31:0] wr_data,

    // multiplier
    output logic        mult_en,
    output logic [31:0] op_a,
    output logic [31:0] op_b,
    input  logic [31:0] hi,
    input  logic [31:0] lo,

    // data memory
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata,

    output logic        active
);

    // fetch state
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        halted;

    // decoded word
    instr_t      instr;
    logic        is_special;
    logic        is_jr;
    logic        is_multu;
    logic        is_mfhi;
    logic        is_mflo;
    logic        is_lw;
    logic        is_sw;
    logic        is_addiu;

    // address and adder result
    logic [31:0] sext_imm;
    logic [31:0] addr_sum;

    assign instr_address = pc;
    assign instr         = instr_readdata;

    // low in reset, then high from the first cycle until pc hits zero
    assign active = arst_n & ~halted;

    assign is_special = (instr.r.opcode == op_special);
    assign is_jr      = is_special && (instr.r.funct == fn_jr);
    assign is_multu   = is_special && (instr.r.funct == fn_multu);
    assign is_mfhi    = is_special && (instr.r.funct == fn_mfhi);
    assign is_mflo    = is_special && (instr.r.funct == fn_mflo);
    assign is_lw      = (instr.i.opcode == op_lw);
    assign is_sw      = (instr.i.opcode == op_sw);
    assign is_addiu   = (instr.i.opcode == op_addiu);

    // both formats share rs and rt positions
    assign rs_addr = instr.i.rs;
    assign rt_addr = instr.i.rt;

    // base plus signed offset, shared by lw, sw and addiu
    assign sext_imm = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign addr_sum = rs_data + sext_imm;

    // data bus, strobes only while running
    assign data_address   = addr_sum;
    assign data_writedata = rt_data;
    assign data_read      = active & is_lw;
    assign data_write     = active & is_sw;

    // multiply operands straight from the read ports
    assign op_a    = rs_data;
    assign op_b    = rt_data;
    assign mult_en = active & is_multu;

    // write-back: i-type to rt, mfhi/mflo to rd
    assign wr_en   = active & (is_lw | is_addiu | is_mfhi | is_mflo);
    assign wr_addr = (is_mfhi | is_mflo) ? instr.r.rd : instr.i.rt;

    always_comb begin
        if (is_lw) begin
            wr_data = data_readdata;
        end else if (is_mfhi) begin
            wr_data = hi;
        end else if (is_mflo) begin
            wr_data = lo;
        end else begin
            // addiu
            wr_data = addr_sum;
        end
    end

    // pc pair gives the jr delay slot, target lands one instruction late
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= reset_vector;
            next_pc <= reset_vector + 32'd4;
            halted  <= 1'b0;
        end else begin
            if (active) begin
                pc <= next_pc;
                if (is_jr) begin
                    next_pc <= rs_data;
                end else begin
                    next_pc <= next_pc + 32'd4;
                end
                // pc about to become zero, freeze everything
                if (next_pc == 32'h0) begin
                    halted <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/mips_top.sv
`timescale 1ns/1ps

module mips_top import mips_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata,
    output logic        active
);

    // fetch path
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;

    // register file path
    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;

    // multiplier path
    logic        mult_en;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] hi;
    logic [31:0] lo;

    mips_core core0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .rs_addr        (rs_addr),
        .rt_addr        (rt_addr),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .mult_en        (mult_en),
        .op_a           (op_a),
        .op_b           (op_b),
        .hi             (hi),
        .lo             (lo),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata),
        .active         (active)
    );

    reg_file regs0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    hilo_unit hilo0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .mult_en (mult_en),
        .op_a    (op_a),
        .op_b    (op_b),
        .hi      (hi),
        .lo      (lo)
    );

    instr_rom rom0 (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

endmodule

//--- test/mips_tb.sv
`timescale 1ns/1ps

module mips_tb;

    localparam int reset_cycles   = 5;
    localparam int num_loads      = 15;
    localparam int num_stores     = 28;
    // 15 loads, 42 multu/mflo/mfhi, 28 stores, jr and its delay slot
    localparam int program_cycles = 87;
    localparam int idle_cycles    = 10;
    // more than twice the program length
    localparam int cycle_limit    = 200;
    localparam int golden_words   = num_loads + 2 * num_stores;
    localparam int mem_words      = 512;
    localparam logic [31:0] store_base = 32'h0000_0400;

    logic        clk;
    logic        arst_n;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;
    logic        active;

    // load words first, then store address and data pairs
    logic [31:0] golden [0:golden_words-1];
    // data memory seen by the core
    logic [31:0] mem [0:mem_words-1];

    // bus activity in program order
    logic [31:0] read_log [$];
    logic [31:0] store_addr_log [$];
    logic [31:0] store_data_log [$];

    int cycle_count  = 0;
    int error_count  = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int active_cycles;
    int errors_before;
    int seed;

    mips_top dut0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata),
        .active         (active)
    );

    always #50 clk = ~clk;

    // memory answers in the same cycle
    assign data_readdata = mem[data_address[10:2]];

    // bus sampled mid-cycle where strobes and address have settled
    always @(negedge clk) begin
        if (arst_n && data_read) begin
            read_log.push_back(data_address);
        end
        if (arst_n && data_write) begin
            mem[data_address[10:2]] = data_writedata;
            store_addr_log.push_back(data_address);
            store_data_log.push_back(data_writedata);
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the program did not halt within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got %08h, expected %08h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic report_result(input string name, input int errors_at_start);
        if (error_count == errors_at_start) begin
            $display("%s: ok", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", name, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    initial begin
        logic [63:0] product;
        logic [31:0] expect_word;
        int          k;

        // stimulus and expected words come from the golden file
        seed   = 21;
        clk    = 1'b0;
        arst_n = 1'b0;

        $readmemh("test/multu_golden.mem", golden);
        if ($isunknown(golden[golden_words-1])) begin
            $display("golden file test/multu_golden.mem is missing or holds too few words");
            error_count++;
        end

        // fill pattern from the byte address, load words at the bottom
        for (int a = 0; a < mem_words; a++) begin
            mem[a] = 32'hA5C3_0000 ^ 32'(a * 4);
        end
        for (int a = 0; a < num_loads; a++) begin
            mem[a] = golden[a];
        end

        // reset held over five rising edges, bus quiet throughout
        errors_before = error_count;
        repeat (reset_cycles - 1) begin
            @(negedge clk);
            check_value("data_read", 32'(data_read), 32'h0);
            check_value("data_write", 32'(data_write), 32'h0);
            check_value("active", 32'(active), 32'h0);
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;

        // first instruction at the boot address right after release
        @(negedge clk);
        check_value("active", 32'(active), 32'h1);
        check_value("data_read", 32'(data_read), 32'h1);
        check_value("data_address", data_address, 32'h0);
        report_result("reset and start", errors_before);

        // one instruction per clock until pc reaches zero
        errors_before = error_count;
        active_cycles = 0;
        while (active) begin
            active_cycles++;
            @(negedge clk);
        end
        check_value("active cycles", 32'(active_cycles), 32'(program_cycles));
        for (int c = 0; c < idle_cycles; c++) begin
            check_value("active", 32'(active), 32'h0);
            check_value("data_read", 32'(data_read), 32'h0);
            check_value("data_write", 32'(data_write), 32'h0);
            @(negedge clk);
        end
        report_result("halt", errors_before);

        // away from the sampling edge before reading the logs
        @(posedge clk);

        errors_before = error_count;
        check_value("data_read count", 32'(read_log.size()), 32'(num_loads));
        for (int i = 0; i < num_loads && i < read_log.size(); i++) begin
            check_value($sformatf("data_address, load %0d", i), read_log[i], 32'(4 * i));
        end
        report_result("loads", errors_before);

        // stores walk up from 0x400, hi then lo of each product
        errors_before = error_count;
        check_value("data_write count", 32'(store_addr_log.size()), 32'(num_stores));
        for (int i = 0; i < num_stores && i < store_addr_log.size(); i++) begin
            check_value($sformatf("data_address, store %0d", i), store_addr_log[i],
                        store_base + 32'(4 * i));
            check_value($sformatf("data_address, store %0d vs golden", i),
                        store_addr_log[i], golden[num_loads + 2 * i]);
        end
        report_result("store addresses", errors_before);

        errors_before = error_count;
        for (int i = 0; i < num_stores && i < store_data_log.size(); i++) begin
            // product k pairs load word k with load word k+1
            k       = i / 2;
            product = {32'h0, golden[k]} * {32'h0, golden[k + 1]};
            if (i % 2 == 0) begin
                expect_word = product[63:32];
            end else begin
                expect_word = product[31:0];
            end
            check_value($sformatf("data_writedata, store %0d vs golden", i),
                        store_data_log[i], golden[num_loads + 2 * i + 1]);
            check_value($sformatf("data_writedata, store %0d vs product", i),
                        store_data_log[i], expect_word);
        end
        report_result("store data", errors_before);

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- test/multu_golden.mem
// first 15 lines: load words for r2 .. r16 at byte addresses 0 .. 56
// then 28 lines: store address, store data (even index hi word, odd index lo word)
ffffffff
ffffffff
80000000
00000002
12345678
00010000
00010000
00000000
deadbeef
00000010
10000000
ffffffff
00000003
aaaaaaab
00000005
00000400 fffffffe
00000404 00000001
00000408 7fffffff
0000040c 80000000
00000410 00000001
00000414 00000000
00000418 00000000
0000041c 2468acf0
00000420 00001234
00000424 56780000
00000428 00000001
0000042c 00000000
00000430 00000000
00000434 00000000
00000438 00000000
0000043c 00000000
00000440 0000000d
00000444 eadbeef0
00000448 00000001
0000044c 00000000
00000450 0fffffff
00000454 f0000000
00000458 00000002
0000045c fffffffd
00000460 00000002
00000464 00000001
00000468 00000003
0000046c 55555557

//--- mips_multu.f
hw/mips_pkg.sv
hw/instr_rom.sv
hw/reg_file.sv
hw/hilo_unit.sv
hw/mips_core.sv
hw/mips_top.sv
test/mips_tb.sv

//--- run.sh
#!/bin/sh
# build the multu testbench with verilator, run it and scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module mips_tb -f mips_multu.f \
    && ./obj_dir/Vmips_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
